// ==== Makefile ====
# Verilator build and run for the LED panel testbench

TOP ?= tb_led_panel
RTL_TOP ?= led_panel_top
SIM_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= filelist.f
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run
	@if grep -qx "Test passed" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST) src/led_panel_cfg.svh
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(SIM_DIR)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(SIM_DIR) $(LOG)

// ==== filelist.f ====
+incdir+src
src/led_panel_pkg.sv
src/wb_pixel_port.sv
src/frame_mem.sv
src/scan_counter.sv
src/scan_ctrl.sv
src/led_panel_top.sv
sim/tb_led_panel.sv

// ==== sim/tb_led_panel.sv ====
`timescale 1ns/100ps
`include "led_panel_cfg.svh"

module tb_led_panel;
	import led_panel_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int NUM_ENTRIES = 10;
	localparam int ROW_CYCLES = 3 * `LED_COLS + 2 + `LED_BLANK_CYCLES;
	localparam int FRAME_CYCLES = ROW_CYCLES * `LED_ROWS;
	localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 20 * NUM_ENTRIES + RESET_CYCLES;
	localparam int PIXELS = 2 * `LED_ROWS * `LED_COLS;

	typedef struct packed {
		wb_adr_t adr;
		wb_dat_t dat;
		logic we;
		logic expect_write;
	} stim_t;

	logic clk;
	logic rst;
	wb_req_t wb_req;
	logic wb_ack;
	panel_t panel;

	stim_t tbl [NUM_ENTRIES];
	pixel_t shadow [PIXELS]; // expected frame contents
	int seed;
	logic pix_check;

	// scan monitor state
	int cycle_cnt;
	int last_latch_cyc;
	int col_exp;
	int row_exp;
	int oe_low_cnt;
	int latch_cnt;
	logic prev_dclk;
	logic prev_latch;
	logic prev_oe_n;
	logic blank_open;
	logic blank_done;

	led_panel_top DUT (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_ack(wb_ack),
		.panel(panel)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%0t: %s", $time, what);
		stop_with_failure();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// {region, 2'b00, half, row, col, byte offset}
	function automatic wb_adr_t make_adr(input logic [15:0] region, input logic half,
		input row_t row, input col_t col);
		return {region, 2'b00, half, row, col, 2'b00};
	endfunction

	function automatic pix_addr_t pix_index(input logic half, input row_t row, input col_t col);
		return {half, row, col};
	endfunction

	task automatic set_entry(input int i, input wb_adr_t adr, input logic we,
		input logic expect_write);
		tbl[i].adr = adr;
		tbl[i].dat = $random(seed);
		tbl[i].we = we;
		tbl[i].expect_write = expect_write;
		if (tbl[i].dat[3:0] == 4'h0) begin
			tbl[i].dat[3:0] = 4'ha; // keep written pixels distinct from the cleared memory
		end
	endtask

	task automatic build_stimulus();
		row_t last_row;
		col_t last_col;
		last_row = row_t'(`LED_ROWS - 1);
		last_col = col_t'(`LED_COLS - 1);
		set_entry(0, make_adr(`LED_FB_REGION, 1'b0, 5'd0, 6'd0), 1'b1, 1'b1);
		set_entry(1, make_adr(`LED_FB_REGION, 1'b1, 5'd0, last_col), 1'b1, 1'b1);
		set_entry(2, make_adr(`LED_FB_REGION, 1'b0, 5'd1, 6'd5), 1'b1, 1'b1);
		set_entry(3, make_adr(`LED_FB_REGION, 1'b1, 5'd1, 6'd40), 1'b1, 1'b1);
		set_entry(4, make_adr(`LED_FB_REGION, 1'b0, last_row, last_col), 1'b1, 1'b1);
		set_entry(5, make_adr(`LED_FB_REGION, 1'b1, last_row, 6'd0), 1'b1, 1'b1);
		set_entry(6, make_adr(16'h0003, 1'b1, last_row, 6'd0), 1'b1, 1'b0); // wrong region
		set_entry(7, make_adr(`LED_FB_REGION, 1'b1, 5'd1, 6'd40), 1'b0, 1'b0); // read cycle
		set_entry(8, make_adr(`LED_FB_REGION, 1'b0, 5'd1, 6'd5), 1'b1, 1'b1); // overwrite
		set_entry(9, make_adr(16'h0000, 1'b0, 5'd0, 6'd0), 1'b1, 1'b0);
		// ignored cycles and the overwrite carry data that differs from the stored pixel
		tbl[6].dat[3:0] = ~tbl[5].dat[3:0];
		tbl[7].dat[3:0] = ~tbl[3].dat[3:0];
		tbl[8].dat[3:0] = ~tbl[2].dat[3:0];
		tbl[9].dat[3:0] = ~tbl[0].dat[3:0];
	endtask

	task automatic check_reset_outputs();
		check_value("display_clk", 32'(panel.display_clk), 0);
		check_value("latch", 32'(panel.latch), 0);
		check_value("oe_n", 32'(panel.oe_n), 1);
		check_value("row_addr", 32'(panel.row_addr), 0);
		check_value("col_addr", 32'(panel.col_addr), 0);
		check_value("rgb_top", 32'(panel.rgb_top), 0);
		check_value("rgb_bot", 32'(panel.rgb_bot), 0);
		check_value("wb_ack", 32'(wb_ack), 0);
	endtask

	// starts and ends on a falling edge
	task automatic bus_write(input stim_t s);
		wb_req_t req;
		int waited;
		check_value("wb_ack before request", 32'(wb_ack), 0);
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = s.we;
		req.adr = s.adr;
		req.dat = s.dat;
		wb_req <= req;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < 8);
		if (!wb_ack) begin
			report_failure("bus slave gave no ack within 8 cycles");
		end
		check_value("wb_ack latency", waited, 1);
		wb_req <= '0;
		@(negedge clk);
		check_value("wb_ack second cycle", 32'(wb_ack), 0);
	endtask

	always @(negedge clk) begin
		if (rst) begin
			cycle_cnt = 0;
			last_latch_cyc = 0;
			col_exp = 0;
			row_exp = 0;
			oe_low_cnt = 0;
			latch_cnt = 0;
			prev_dclk = 1'b0;
			prev_latch = 1'b0;
			prev_oe_n = 1'b1;
			blank_open = 1'b0;
			blank_done = 1'b0;
		end else begin
			cycle_cnt++;
			if (panel.display_clk) begin
				check_value("display_clk width", 32'(prev_dclk), 0);
				check_value("col_addr", 32'(panel.col_addr), col_exp);
				check_value("row_addr", 32'(panel.row_addr), row_exp);
				if (pix_check) begin
					check_value("rgb_top", 32'(panel.rgb_top),
						32'(shadow[pix_index(1'b0, row_t'(row_exp), col_t'(col_exp))]));
					check_value("rgb_bot", 32'(panel.rgb_bot),
						32'(shadow[pix_index(1'b1, row_t'(row_exp), col_t'(col_exp))]));
				end
				col_exp++;
			end
			if (panel.latch) begin
				check_value("latch width", 32'(prev_latch), 0);
				check_value("display_clk at latch", 32'(panel.display_clk), 0);
				check_value("display_clk pulses per row", col_exp, `LED_COLS);
				check_value("row_addr at latch", 32'(panel.row_addr), row_exp);
				if (latch_cnt > 0) begin
					check_value("blanking before latch", 32'(blank_done), 1);
					check_value("latch period", cycle_cnt - last_latch_cyc, ROW_CYCLES);
				end
				last_latch_cyc = cycle_cnt;
				latch_cnt++;
				col_exp = 0;
				row_exp = (row_exp + 1) % `LED_ROWS; // wraps at end of frame
				blank_open = 1'b1;
				blank_done = 1'b0;
			end else if (prev_latch) begin
				check_value("row_addr after latch", 32'(panel.row_addr), row_exp);
			end
			if (!panel.oe_n) begin
				check_value("oe_n low outside blanking", 32'(blank_open), 1);
				oe_low_cnt++;
			end else if (!prev_oe_n) begin
				check_value("oe_n low cycles", oe_low_cnt, `LED_BLANK_CYCLES);
				oe_low_cnt = 0;
				blank_open = 1'b0;
				blank_done = 1'b1;
			end
			prev_dclk = panel.display_clk;
			prev_latch = panel.latch;
			prev_oe_n = panel.oe_n;
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		report_failure("simulation timed out before the scan checks completed");
	end

	initial begin
		int start_latches;
		seed = 32'h9c5d78dd;
		rst = 1'b1;
		wb_req = '0;
		pix_check = 1'b0;
		for (int i = 0; i < PIXELS; i++) begin
			shadow[i] = '0;
		end
		build_stimulus();
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_reset_outputs();
		end
		rst <= 1'b0;
		@(negedge clk);
		check_reset_outputs();
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			bus_write(tbl[i]);
			if (tbl[i].expect_write) begin
				shadow[tbl[i].adr[13:2]] = tbl[i].dat[3:0];
			end
		end
		pix_check <= 1'b1;
		start_latches = latch_cnt;
		wait (latch_cnt >= start_latches + `LED_ROWS + 1); // one full frame plus wrap
		$display("Test passed");
		$finish;
	end

endmodule

// ==== src/frame_mem.sv ====
`timescale 1ns/100ps

module frame_mem (
	input logic clk,
	input logic rst,
	input led_panel_pkg::pix_wr_t pix_wr,
	input logic rd_en,
	input led_panel_pkg::scan_pos_t pos,
	output led_panel_pkg::pixel_t rgb_top,
	output led_panel_pkg::pixel_t rgb_bot
);
	import led_panel_pkg::*;

	localparam int DEPTH = 2 ** $bits(pix_addr_t);

	// two copies so both halves read in the same cycle
	pixel_t mem_top [DEPTH];
	pixel_t mem_bot [DEPTH];

	pix_addr_t top_addr;
	pix_addr_t bot_addr;

	assign top_addr = {1'b0, pos};
	assign bot_addr = {1'b1, pos};

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem_top[i] = '0;
			mem_bot[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (pix_wr.en) begin
			mem_top[pix_wr.addr] <= pix_wr.data;
			mem_bot[pix_wr.addr] <= pix_wr.data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb_top <= '0;
			rgb_bot <= '0;
		end else if (rd_en) begin
			rgb_top <= mem_top[top_addr];
			rgb_bot <= mem_bot[bot_addr];
		end
	end

endmodule

// ==== src/led_panel_cfg.svh ====
`ifndef LED_PANEL_CFG_SVH
`define LED_PANEL_CFG_SVH

// panel geometry, one half of a 64x64 HUB panel
`define LED_COLS 64
`define LED_ROWS 32

// cycles with the display on after each latch
`define LED_BLANK_CYCLES 3

// colour bits per pixel
`define LED_PIXEL_W 4

// host bus
`define LED_WB_ADR_W 32
`define LED_WB_DAT_W 32

// frame buffer sits in the 64 KiB region 0x0002_xxxx
`define LED_FB_REGION 16'h0002
`define LED_FB_REGION_W 16

`endif

// ==== src/led_panel_pkg.sv ====
`include "led_panel_cfg.svh"

package led_panel_pkg;

	typedef logic [$clog2(`LED_COLS)-1:0] col_t;
	typedef logic [$clog2(`LED_ROWS)-1:0] row_t;
	typedef logic [`LED_PIXEL_W-1:0] pixel_t;
	typedef logic [$clog2(`LED_ROWS * `LED_COLS):0] pix_addr_t; // {half, row, col}

	typedef logic [`LED_WB_ADR_W-1:0] wb_adr_t;
	typedef logic [`LED_WB_DAT_W-1:0] wb_dat_t;

	// master side of a Wishbone classic cycle
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	typedef struct packed {
		logic en;
		pix_addr_t addr;
		pixel_t data;
	} pix_wr_t;

	typedef struct packed {
		row_t row;
		col_t col;
	} scan_pos_t;

	typedef struct packed {
		logic col_step;
		logic row_step;
	} scan_step_t;

	typedef struct packed {
		row_t row_addr;
		col_t col_addr;
		logic display_clk;
		logic latch;
		logic oe_n;
		pixel_t rgb_top;
		pixel_t rgb_bot;
	} panel_t;

	typedef enum logic [2:0] {
		FETCH,
		SHIFT_HIGH,
		SHIFT_LOW,
		LATCH_HIGH,
		LATCH_LOW,
		BLANK
	} scan_state_t;

endpackage

// ==== src/led_panel_top.sv ====
`timescale 1ns/100ps

module led_panel_top (
	input logic clk,
	input logic rst,
	input led_panel_pkg::wb_req_t wb_req,
	output logic wb_ack,
	output led_panel_pkg::panel_t panel
);
	import led_panel_pkg::*;

	pix_wr_t pix_wr;
	scan_step_t step;
	scan_pos_t pos;
	logic col_last;
	logic rd_en;
	logic display_clk;
	logic latch;
	logic oe_n;
	pixel_t rgb_top;
	pixel_t rgb_bot;

	wb_pixel_port u_port (
		.clk(clk),
		.rst(rst),
		.req(wb_req),
		.ack(wb_ack),
		.pix_wr(pix_wr)
	);

	frame_mem u_mem (
		.clk(clk),
		.rst(rst),
		.pix_wr(pix_wr),
		.rd_en(rd_en),
		.pos(pos),
		.rgb_top(rgb_top),
		.rgb_bot(rgb_bot)
	);

	scan_counter u_cnt (
		.clk(clk),
		.rst(rst),
		.step(step),
		.pos(pos),
		.col_last(col_last)
	);

	scan_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.col_last(col_last),
		.step(step),
		.rd_en(rd_en),
		.display_clk(display_clk),
		.latch(latch),
		.oe_n(oe_n)
	);

	always_comb begin
		panel.row_addr = pos.row;
		panel.col_addr = pos.col;
		panel.display_clk = display_clk;
		panel.latch = latch;
		panel.oe_n = oe_n;
		panel.rgb_top = rgb_top;
		panel.rgb_bot = rgb_bot;
	end

endmodule

// ==== src/scan_counter.sv ====
`timescale 1ns/100ps
`include "led_panel_cfg.svh"

module scan_counter (
	input logic clk,
	input logic rst,
	input led_panel_pkg::scan_step_t step,
	output led_panel_pkg::scan_pos_t pos,
	output logic col_last
);
	import led_panel_pkg::*;

	localparam col_t COL_MAX = col_t'(`LED_COLS - 1);
	localparam row_t ROW_MAX = row_t'(`LED_ROWS - 1);

	assign col_last = (pos.col == COL_MAX);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pos.col <= '0;
		end else if (step.col_step) begin
			if (col_last) begin
				pos.col <= '0;
			end else begin
				pos.col <= pos.col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pos.row <= '0;
		end else if (step.row_step) begin
			if (pos.row == ROW_MAX) begin
				pos.row <= '0; // next frame
			end else begin
				pos.row <= pos.row + 1'b1;
			end
		end
	end

endmodule

// ==== src/scan_ctrl.sv ====
`timescale 1ns/100ps
`include "led_panel_cfg.svh"

module scan_ctrl (
	input logic clk,
	input logic rst,
	input logic col_last,
	output led_panel_pkg::scan_step_t step,
	output logic rd_en,
	output logic display_clk,
	output logic latch,
	output logic oe_n
);
	import led_panel_pkg::*;

	localparam int DWELL_W = $clog2(`LED_BLANK_CYCLES + 1);
	localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(`LED_BLANK_CYCLES - 1);

	scan_state_t state;
	scan_state_t state_nxt;
	logic [DWELL_W-1:0] dwell;
	logic dwell_done;

	assign dwell_done = (dwell == DWELL_LAST);

	// counters move on the exit edge of the state
	assign step.col_step = (state == SHIFT_LOW);
	assign step.row_step = (state == LATCH_LOW);

	always_comb begin
		state_nxt = state;
		case (state)
			FETCH: begin
				state_nxt = SHIFT_HIGH;
			end
			SHIFT_HIGH: begin
				state_nxt = SHIFT_LOW;
			end
			SHIFT_LOW: begin
				if (col_last) begin
					state_nxt = LATCH_HIGH; // row fully shifted
				end else begin
					state_nxt = FETCH;
				end
			end
			LATCH_HIGH: begin
				state_nxt = LATCH_LOW;
			end
			LATCH_LOW: begin
				state_nxt = BLANK;
			end
			BLANK: begin
				if (dwell_done) begin
					state_nxt = FETCH;
				end
			end
			default: begin
				state_nxt = FETCH;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= FETCH;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dwell <= '0;
		end else if (state == BLANK) begin
			if (dwell_done) begin
				dwell <= '0;
			end else begin
				dwell <= dwell + 1'b1;
			end
		end
	end

	// strobes follow the state by one edge, pixel data lands with display_clk
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_en <= 1'b0;
			display_clk <= 1'b0;
			latch <= 1'b0;
			oe_n <= 1'b1; // display off
		end else begin
			rd_en <= (state == FETCH);
			display_clk <= (state == SHIFT_HIGH);
			latch <= (state == LATCH_HIGH);
			oe_n <= (state != BLANK);
		end
	end

endmodule

// ==== src/wb_pixel_port.sv ====
`timescale 1ns/100ps
`include "led_panel_cfg.svh"

module wb_pixel_port (
	input logic clk,
	input logic rst,
	input led_panel_pkg::wb_req_t req,
	output logic ack,
	output led_panel_pkg::pix_wr_t pix_wr
);
	import led_panel_pkg::*;

	logic req_seen;
	logic in_region;

	// new request, not yet acknowledged
	assign req_seen = req.cyc & req.stb & ~ack;

	assign in_region = (req.adr[`LED_WB_ADR_W-1 -: `LED_FB_REGION_W] ==
		`LED_FB_REGION_W'(`LED_FB_REGION));

	// classic single-cycle ack, one cycle after the request
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ack <= 1'b0;
		end else begin
			ack <= req_seen;
		end
	end

	// write strobe is taken by frame_mem on the edge that raises ack
	always_comb begin
		pix_wr.en = req_seen & req.we & in_region;
		pix_wr.addr = req.adr[2 +: $bits(pix_addr_t)]; // word addressed
		pix_wr.data = req.dat[$bits(pixel_t)-1:0];
	end

endmodule
